// File: logic/icachePkg.sv
package icachePkg;

    // cache geometry
    localparam int numWays      = 4;
    localparam int numSets      = 64;
    localparam int wordsPerLine = 4;

    // address fields: [3:0] byte in line, [9:4] set, [31:10] tag
    localparam int indexLo = 4;
    localparam int indexHi = 9;
    localparam int tagLo   = 10;

    typedef logic [31:0] addrT;
    typedef logic [31:tagLo] tagT;
    typedef logic [indexHi-indexLo:0] indexT;
    typedef logic [31:0] instT;
    typedef logic [wordsPerLine*$bits(instT)-1:0] lineT;
    typedef logic [$clog2(numWays)-1:0] wayT;

    // tree pseudo-LRU bits of one set
    typedef logic [2:0] ageT;

endpackage

// File: logic/syncRam.sv
`timescale 1ns/1ps

module syncRam
    import icachePkg::*;
#(
    parameter type ramWord = lineT,
    parameter int  depth   = numSets
) (
    input  logic   clk,
    input  logic   writeEn,
    input  indexT  addr,
    input  ramWord writeData,
    output ramWord readData
);

    ramWord mem [depth];

    // read returns the old word when written in the same cycle
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr] <= writeData;
        end
        readData <= mem[addr];
    end

endmodule

// File: logic/wayArray.sv
`timescale 1ns/1ps

module wayArray
    import icachePkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  indexT              lookupIndex,
    input  tagT                lookupTag,
    input  logic               fillEn,
    input  wayT                fillWay,
    input  tagT                fillTag,
    input  lineT               fillLine,
    output logic               hit,
    output wayT                hitWay,
    output lineT               hitLine,
    output logic [numWays-1:0] wayValid
);

    logic [numWays-1:0] validBits [numSets];
    indexT              lookedIndex;
    tagT                tagRd [numWays];
    lineT               lineRd [numWays];
    logic [numWays-1:0] wayHit;

    for (genvar w = 0; w < numWays; w++) begin : gWay
        logic wayWrite;

        assign wayWrite = fillEn && (fillWay == wayT'(w));

        syncRam #(.ramWord(tagT), .depth(numSets)) tagRam (
            .clk       (clk),
            .writeEn   (wayWrite),
            .addr      (lookupIndex),
            .writeData (fillTag),
            .readData  (tagRd[w])
        );

        syncRam #(.ramWord(lineT), .depth(numSets)) lineRam (
            .clk       (clk),
            .writeEn   (wayWrite),
            .addr      (lookupIndex),
            .writeData (fillLine),
            .readData  (lineRd[w])
        );

        assign wayHit[w] = wayValid[w] && (tagRd[w] == lookupTag);
    end

    // fills always target the held set, which is on lookupIndex during refill
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int s = 0; s < numSets; s++) begin
                validBits[s] <= '0;
            end
        end else if (fillEn) begin
            validBits[lookupIndex][fillWay] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        lookedIndex <= lookupIndex;
    end

    assign wayValid = validBits[lookedIndex];
    assign hit      = |wayHit;

    // lowest way wins
    always_comb begin
        hitWay = '0;
        for (int w = numWays - 1; w >= 0; w--) begin
            if (wayHit[w]) begin
                hitWay = wayT'(w);
            end
        end
    end

    assign hitLine = lineRd[hitWay];

    // a refill never duplicates a line that is already present
    assert property (@(posedge clk) disable iff (rst) $onehot0(wayHit))
        else $error("more than one way hit");

endmodule

// File: logic/plruTree.sv
`timescale 1ns/1ps

module plruTree
    import icachePkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               touch,
    input  indexT              touchSet,
    input  wayT                touchWay,
    input  logic [numWays-1:0] wayValid,
    output wayT                victimWay
);

    ageT ages [numSets];
    ageT curAge;

    assign curAge = ages[touchSet];

    // bit 2 picks the half to replace next, bits 0 and 1 pick within a half
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int s = 0; s < numSets; s++) begin
                ages[s] <= '0;
            end
        end else if (touch) begin
            case (touchWay)
                2'd0: ages[touchSet] <= {1'b1, curAge[1], 1'b1};
                2'd1: ages[touchSet] <= {1'b1, curAge[1], 1'b0};
                2'd2: ages[touchSet] <= {1'b0, 1'b1, curAge[0]};
                default: ages[touchSet] <= {1'b0, 1'b0, curAge[0]};
            endcase
        end
    end

    // an empty way is always taken first
    always_comb begin
        if (!wayValid[0]) begin
            victimWay = 2'd0;
        end else if (!wayValid[1]) begin
            victimWay = 2'd1;
        end else if (!wayValid[2]) begin
            victimWay = 2'd2;
        end else if (!wayValid[3]) begin
            victimWay = 2'd3;
        end else if (!curAge[2]) begin
            victimWay = curAge[0] ? 2'd1 : 2'd0;
        end else begin
            victimWay = curAge[1] ? 2'd3 : 2'd2;
        end
    end

    assert property (@(posedge clk) disable iff (rst) touch |-> !$isunknown(touchWay))
        else $error("touch with unknown way");

endmodule

// File: logic/missControl.sv
`timescale 1ns/1ps

module missControl
    import icachePkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    input  logic  fetchValid,
    input  addrT  fetchAddr,
    input  logic  hit,
    input  wayT   hitWay,
    input  lineT  hitLine,
    input  wayT   victimWay,
    input  logic  memRespValid,
    input  lineT  memRespLine,
    output logic  stall,
    output logic  memReqValid,
    output addrT  memReqAddr,
    output indexT lookupIndex,
    output tagT   lookupTag,
    output logic  fillEn,
    output wayT   fillWay,
    output tagT   fillTag,
    output lineT  fillLine,
    output logic  touch,
    output indexT touchSet,
    output wayT   touchWay,
    output logic  inst0Valid,
    output addrT  inst0Pc,
    output instT  inst0,
    output logic  inst1Valid,
    output addrT  inst1Pc,
    output instT  inst1
);

    // lookup and request both mean an accepted fetch is in flight;
    // request is the forced miss of a fetch taken together with a flush
    typedef enum logic [2:0] {idle, lookup, request, waitFill, fillDone} stateT;

    stateT state, nextState, runNext;
    addrT  heldAddr;
    logic  accept;
    logic  lookupMiss;
    logic  deliver;
    lineT  outLine;
    instT  lineWords [wordsPerLine];

    assign lookupMiss = (state == lookup) && !hit;
    assign stall      = lookupMiss || (state == request) || (state == waitFill);
    assign accept     = fetchValid && !stall;

    assign runNext = accept ? (flush ? request : lookup) : idle;

    always_comb begin
        nextState = state;
        case (state)
            idle, fillDone: nextState = runNext;
            lookup:         nextState = hit ? runNext : waitFill;
            request:        nextState = waitFill;
            waitFill: begin
                if (memRespValid) begin
                    nextState = fillDone;
                end
            end
            default:        nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldAddr <= fetchAddr;
        end
    end

    // the RAMs follow the fetch stream, and stay on the held set while stalled
    assign lookupIndex = stall ? heldAddr[indexHi:indexLo] : fetchAddr[indexHi:indexLo];
    assign lookupTag   = heldAddr[31:tagLo];

    assign memReqValid = lookupMiss || (state == request);
    assign memReqAddr  = {heldAddr[31:indexLo], {indexLo{1'b0}}};

    assign fillEn   = (state == waitFill) && memRespValid;
    assign fillWay  = victimWay;
    assign fillTag  = heldAddr[31:tagLo];
    assign fillLine = memRespLine;

    assign deliver  = ((state == lookup) && hit) || fillEn;
    assign touch    = deliver;
    assign touchSet = heldAddr[indexHi:indexLo];
    assign touchWay = fillEn ? victimWay : hitWay;

    // pair comes straight from memory in the response cycle
    assign outLine = fillEn ? memRespLine : hitLine;

    always_comb begin
        for (int i = 0; i < wordsPerLine; i++) begin
            lineWords[i] = outLine[i*$bits(instT) +: $bits(instT)];
        end
    end

    assign inst0Valid = deliver && !heldAddr[2];
    assign inst1Valid = deliver;
    assign inst0Pc    = {heldAddr[31:3], 3'b000};
    assign inst1Pc    = {heldAddr[31:3], 3'b100};
    assign inst0      = lineWords[{heldAddr[3], 1'b0}];
    assign inst1      = lineWords[{heldAddr[3], 1'b1}];

    assert property (@(posedge clk) disable iff (rst) memRespValid |-> state == waitFill)
        else $error("memory response without outstanding request");

endmodule

// File: logic/instCache.sv
`timescale 1ns/1ps

module instCache
    import icachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic fetchValid,
    input  addrT fetchAddr,
    input  logic memRespValid,
    input  lineT memRespLine,
    output logic stall,
    output logic memReqValid,
    output addrT memReqAddr,
    output logic inst0Valid,
    output addrT inst0Pc,
    output instT inst0,
    output logic inst1Valid,
    output addrT inst1Pc,
    output instT inst1
);

    indexT              lookupIndex;
    tagT                lookupTag;
    logic               hit;
    wayT                hitWay;
    lineT               hitLine;
    logic [numWays-1:0] wayValid;
    logic               fillEn;
    wayT                fillWay;
    tagT                fillTag;
    lineT               fillLine;
    logic               touch;
    indexT              touchSet;
    wayT                touchWay;
    wayT                victimWay;

    missControl control (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .fetchValid   (fetchValid),
        .fetchAddr    (fetchAddr),
        .hit          (hit),
        .hitWay       (hitWay),
        .hitLine      (hitLine),
        .victimWay    (victimWay),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .lookupIndex  (lookupIndex),
        .lookupTag    (lookupTag),
        .fillEn       (fillEn),
        .fillWay      (fillWay),
        .fillTag      (fillTag),
        .fillLine     (fillLine),
        .touch        (touch),
        .touchSet     (touchSet),
        .touchWay     (touchWay),
        .inst0Valid   (inst0Valid),
        .inst0Pc      (inst0Pc),
        .inst0        (inst0),
        .inst1Valid   (inst1Valid),
        .inst1Pc      (inst1Pc),
        .inst1        (inst1)
    );

    wayArray ways (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .lookupIndex (lookupIndex),
        .lookupTag   (lookupTag),
        .fillEn      (fillEn),
        .fillWay     (fillWay),
        .fillTag     (fillTag),
        .fillLine    (fillLine),
        .hit         (hit),
        .hitWay      (hitWay),
        .hitLine     (hitLine),
        .wayValid    (wayValid)
    );

    plruTree ages (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .touch     (touch),
        .touchSet  (touchSet),
        .touchWay  (touchWay),
        .wayValid  (wayValid),
        .victimWay (victimWay)
    );

endmodule

// File: sim/icacheChecker.sv
`timescale 1ns/1ps

module icacheChecker
    import icachePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchValid,
    input  addrT        fetchAddr,
    input  logic        stall,
    input  logic        memReqValid,
    input  addrT        memReqAddr,
    input  logic        inst0Valid,
    input  addrT        inst0Pc,
    input  instT        inst0,
    input  logic        inst1Valid,
    input  addrT        inst1Pc,
    input  instT        inst1,
    input  logic [95:0] expName,
    input  logic        expV0,
    input  instT        expI0,
    input  instT        expI1,
    input  logic        expMiss,
    output int          pending,
    output int          testCount,
    output int          failCount
);

    // one entry per accepted fetch, oldest first
    logic [95:0] nameQ [$];
    addrT        addrQ [$];
    logic        v0Q [$];
    instT        i0Q [$];
    instT        i1Q [$];
    logic        missQ [$];
    addrT        frontAddr;
    int          reqCount;
    int          waitCycles;
    int          passCount;
    logic        testBad;

    initial begin
        pending    = 0;
        testCount  = 0;
        failCount  = 0;
        passCount  = 0;
        reqCount   = 0;
        waitCycles = 0;
        testBad    = 1'b0;
    end

    task automatic finishTest();
        logic [95:0] name;
        addrT        addr;
        addrT        pc0;
        logic        v0;
        instT        i0;
        instT        i1;
        logic        miss;
        logic        actMiss;
        logic        bad;
        name    = nameQ.pop_front();
        addr    = addrQ.pop_front();
        v0      = v0Q.pop_front();
        i0      = i0Q.pop_front();
        i1      = i1Q.pop_front();
        miss    = missQ.pop_front();
        pc0     = {addr[31:3], 3'b000};
        actMiss = reqCount > 0;
        bad     = 1'b1;
        testCount++;
        if (actMiss != miss) begin
            $display("[FAIL] %0s miss: expected %0d actual %0d", name, miss, actMiss);
        end else if (inst0Valid != v0) begin
            $display("[FAIL] %0s inst0Valid: expected %0d actual %0d", name, v0, inst0Valid);
        end else if (inst1 != i1) begin
            $display("[FAIL] %0s inst1: expected %h actual %h", name, i1, inst1);
        end else if (v0 && inst0 != i0) begin
            $display("[FAIL] %0s inst0: expected %h actual %h", name, i0, inst0);
        end else if (inst0Pc != pc0) begin
            $display("[FAIL] %0s inst0Pc: expected %h actual %h", name, pc0, inst0Pc);
        end else if (inst1Pc != (pc0 | 32'h4)) begin
            $display("[FAIL] %0s inst1Pc: expected %h actual %h", name, pc0 | 32'h4, inst1Pc);
        end else if (reqCount > 1) begin
            $display("test %0s sent %0d memory requests for one miss", name, reqCount);
        end else if (actMiss && !stall) begin
            $display("test %0s dropped stall before the response cycle", name);
        end else if (!actMiss && waitCycles != 1) begin
            $display("test %0s hit was delivered %0d cycles after the fetch", name, waitCycles);
        end else begin
            bad = testBad;
        end
        if (bad) begin
            failCount++;
        end else begin
            passCount++;
            $display("[PASS] %0s", name);
        end
    endtask

    task automatic printSummary();
        $display("%0d tests finished, %0d passed, %0d failed", testCount, passCount, failCount);
    endtask

    // outputs are sampled on the falling edge, halfway between drive and capture
    always @(negedge clk) begin
        if (!rst) begin
            if (addrQ.size() > 0) begin
                frontAddr = addrQ[0];
                waitCycles++;
                if (memReqValid) begin
                    reqCount++;
                    if (memReqAddr != {frontAddr[31:4], 4'h0}) begin
                        $display("[FAIL] %0s memReqAddr: expected %h actual %h", nameQ[0],
                            {frontAddr[31:4], 4'h0}, memReqAddr);
                        testBad = 1'b1;
                    end
                end
                if (inst1Valid) begin
                    finishTest();
                    reqCount   = 0;
                    waitCycles = 0;
                    testBad    = 1'b0;
                end else begin
                    if (inst0Valid) begin
                        $display("inst0Valid rose without inst1Valid for %0s", nameQ[0]);
                        testBad = 1'b1;
                    end
                    if (reqCount > 0 && !stall) begin
                        $display("stall fell before the line returned for %0s", nameQ[0]);
                        testBad = 1'b1;
                    end
                    if (reqCount == 0 && waitCycles == 2) begin
                        $display("fetch %0s gave neither a hit nor a memory request", nameQ[0]);
                        testBad = 1'b1;
                    end
                end
            end else if (memReqValid || inst0Valid || inst1Valid) begin
                $display("cache output raised with no fetch in flight");
                failCount++;
            end
            // fetch is taken at the coming rising edge
            if (fetchValid && !stall) begin
                nameQ.push_back(expName);
                addrQ.push_back(fetchAddr);
                v0Q.push_back(expV0);
                i0Q.push_back(expI0);
                i1Q.push_back(expI1);
                missQ.push_back(expMiss);
            end
            pending = addrQ.size();
        end
    end

endmodule

// File: sim/icacheTb.sv
`timescale 1ns/1ps

module icacheTb
    import icachePkg::*;
();

    logic        clk;
    logic        rst;
    logic        flush;
    logic        fetchValid;
    addrT        fetchAddr;
    logic        memRespValid;
    lineT        memRespLine;
    logic        stall;
    logic        memReqValid;
    addrT        memReqAddr;
    logic        inst0Valid;
    addrT        inst0Pc;
    instT        inst0;
    logic        inst1Valid;
    addrT        inst1Pc;
    instT        inst1;
    logic [95:0] expName;
    logic        expV0;
    instT        expI0;
    instT        expI1;
    logic        expMiss;
    int          pending;
    int          testCount;
    int          failCount;
    addrT        reqAddr;
    int unsigned respDelay;
    int unsigned seed;
    logic        timedOut;

    instCache dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .fetchValid   (fetchValid),
        .fetchAddr    (fetchAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .stall        (stall),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .inst0Valid   (inst0Valid),
        .inst0Pc      (inst0Pc),
        .inst0        (inst0),
        .inst1Valid   (inst1Valid),
        .inst1Pc      (inst1Pc),
        .inst1        (inst1)
    );

    icacheChecker check (
        .clk         (clk),
        .rst         (rst),
        .fetchValid  (fetchValid),
        .fetchAddr   (fetchAddr),
        .stall       (stall),
        .memReqValid (memReqValid),
        .memReqAddr  (memReqAddr),
        .inst0Valid  (inst0Valid),
        .inst0Pc     (inst0Pc),
        .inst0       (inst0),
        .inst1Valid  (inst1Valid),
        .inst1Pc     (inst1Pc),
        .inst1       (inst1),
        .expName     (expName),
        .expV0       (expV0),
        .expI0       (expI0),
        .expI1       (expI1),
        .expMiss     (expMiss),
        .pending     (pending),
        .testCount   (testCount),
        .failCount   (failCount)
    );

    always #2 clk = ~clk;

    // each memory word holds its own byte address xor 5a5a0000
    function automatic lineT lineAt(addrT base);
        lineT line;
        addrT wordAddr;
        for (int i = 0; i < wordsPerLine; i++) begin
            wordAddr          = base + 4 * i;
            line[i*32 +: 32] = wordAddr ^ 32'h5a5a0000;
        end
        return line;
    endfunction

    task automatic waitStallLow();
        int n;
        n = 0;
        while (stall && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (stall) begin
            $display("timeout waiting for stall to fall");
            timedOut = 1'b1;
        end
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        while (pending > 0 && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending > 0) begin
            $display("timeout waiting for the last fetch to deliver");
            timedOut = 1'b1;
        end
    endtask

    // one request at a time, answered after a random delay
    always @(negedge clk) begin
        if (!rst && memReqValid) begin
            reqAddr   = memReqAddr;
            respDelay = 1 + ($urandom % 8);
            repeat (respDelay) @(posedge clk);
            #1;
            memRespValid = 1'b1;
            memRespLine  = lineAt(reqAddr);
            @(posedge clk);
            #1;
            memRespValid = 1'b0;
        end
    end

    initial begin : stimulus
        logic [8*128-1:0] header;
        logic [95:0]      name;
        logic [39:0]      op;
        addrT             addr;
        logic             v0;
        logic             miss;
        instT             i0;
        instT             i1;
        int               fd;
        int               fetchRows;
        int               dummy;
        seed         = 32'hac06;
        dummy        = $urandom(seed);
        clk          = 1'b0;
        rst          = 1'b1;
        flush        = 1'b0;
        fetchValid   = 1'b0;
        fetchAddr    = '0;
        memRespValid = 1'b0;
        memRespLine  = '0;
        expName      = '0;
        expV0        = 1'b0;
        expI0        = '0;
        expI1        = '0;
        expMiss      = 1'b0;
        fetchRows    = 0;
        timedOut     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        fd  = $fopen("sim/icacheTestdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/icacheTestdata.txt");
            $display(">>> FAIL");
            $finish;
        end else begin
            // first line names the columns
            dummy = $fgets(header, fd);
            while (!timedOut && $fscanf(fd, "%s %s %h %h %h %h %h\n",
                    name, op, addr, v0, i0, i1, miss) == 7) begin
                waitStallLow();
                if (!timedOut && op == "flush") begin
                    flush = 1'b1;
                    @(posedge clk);
                    #1;
                    flush = 1'b0;
                end else if (!timedOut) begin
                    fetchValid = 1'b1;
                    fetchAddr  = addr;
                    expName    = name;
                    expV0      = v0;
                    expI0      = i0;
                    expI1      = i1;
                    expMiss    = miss;
                    fetchRows++;
                    @(posedge clk);
                    #1;
                    fetchValid = 1'b0;
                end
            end
            $fclose(fd);
            if (!timedOut) begin
                waitDrained();
            end
            repeat (2) @(posedge clk);
            check.printSummary();
            if (!timedOut && failCount == 0 && testCount == fetchRows) begin
                $display(">>> PASS");
            end else begin
                if (testCount != fetchRows) begin
                    $display("%0d fetches in the data file but %0d tests finished",
                        fetchRows, testCount);
                end
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

// File: sim/icacheTestdata.txt
name op addr(hex) inst0Valid inst0(hex) inst1(hex) miss
cold0 fetch 00001000 1 5a5a1000 5a5a1004 1
hit0 fetch 00001008 1 5a5a1008 5a5a100c 0
hit1 fetch 00001000 1 5a5a1000 5a5a1004 0
odd0 fetch 00001004 0 5a5a1000 5a5a1004 0
odd1 fetch 0000100c 0 5a5a1008 5a5a100c 0
cold1 fetch 00002134 0 5a5a2130 5a5a2134 1
hit2 fetch 00002138 1 5a5a2138 5a5a213c 0
repA fetch 00000450 1 5a5a0450 5a5a0454 1
repB fetch 00000850 1 5a5a0850 5a5a0854 1
repC fetch 00000c50 1 5a5a0c50 5a5a0c54 1
repD fetch 00001050 1 5a5a1050 5a5a1054 1
touchA fetch 00000454 0 5a5a0450 5a5a0454 0
repE fetch 00001458 1 5a5a1458 5a5a145c 1
refC fetch 00000c50 1 5a5a0c50 5a5a0c54 1
refA fetch 00000458 1 5a5a0458 5a5a045c 0
refD fetch 0000105c 0 5a5a1058 5a5a105c 0
refB fetch 00000850 1 5a5a0850 5a5a0854 1
refE fetch 00001450 1 5a5a1450 5a5a1454 0
refC2 fetch 00000c58 1 5a5a0c58 5a5a0c5c 1
refA2 fetch 00000450 1 5a5a0450 5a5a0454 1
refB2 fetch 00000854 0 5a5a0850 5a5a0854 0
flush0 flush 00000000 0 00000000 00000000 0
postA fetch 00001000 1 5a5a1000 5a5a1004 1
postC fetch 00000c50 1 5a5a0c50 5a5a0c54 1
postA2 fetch 0000100c 0 5a5a1008 5a5a100c 0

// File: sim.f
logic/icachePkg.sv
logic/syncRam.sv
logic/wayArray.sv
logic/plruTree.sv
logic/missControl.sv
logic/instCache.sv
sim/icacheChecker.sv
sim/icacheTb.sv
